/* verilog/mips_exc_pkg.sv */
package mips_exc_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // committed instruction class
    typedef enum logic [3:0] {
        OP_NORMAL   = 4'd0,
        OP_ALU_OV   = 4'd1,     // trapping add/sub
        OP_SYSCALL  = 4'd2,
        OP_BREAK    = 4'd3,
        OP_ERET     = 4'd4,
        OP_LW       = 4'd5,
        OP_LH       = 4'd6,
        OP_SW       = 4'd7,
        OP_SH       = 4'd8,
        OP_RESERVED = 4'd9
    } op_e;

    // detected exception, highest priority first
    typedef enum logic [3:0] {
        EXC_NONE   = 4'd0,
        EXC_ADEL_I = 4'd1,
        EXC_RI     = 4'd2,
        EXC_OV     = 4'd3,
        EXC_SYS    = 4'd4,
        EXC_BP     = 4'd5,
        EXC_ERET   = 4'd6,
        EXC_ADEL_D = 4'd7,
        EXC_ADES   = 4'd8
    } exc_kind_e;

    // Cause.ExcCode encodings
    typedef enum logic [4:0] {
        EC_INT  = 5'h00,
        EC_ADEL = 5'h04,
        EC_ADES = 5'h05,
        EC_SYS  = 5'h08,
        EC_BP   = 5'h09,
        EC_RI   = 5'h0a,
        EC_OV   = 5'h0c
    } exccode_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic        in_delay_slot;
        op_e         op;
        logic [31:0] mem_addr;
        logic        alu_ovf;         // add/sub result overflowed
    } lane_in_t;

    typedef struct packed {
        logic        valid;
        exc_kind_e   kind;
        logic        bd;
        logic [31:0] epc;
        logic [31:0] badvaddr;
    } lane_exc_t;

    typedef struct packed {
        logic        update_ena;      // take exception, set EXL
        exccode_e    exccode;
        logic        bd;
        logic [31:0] epc;
        logic        badvaddr_ena;
        logic [31:0] badvaddr;
        logic        cls_exl;         // eret
    } cp0_upd_t;

endpackage

/* verilog/commit_lanes.sv */
`timescale 1ns/1ps

module commit_lanes #(
    parameter int N_LANES = 2
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  mips_exc_pkg::lane_in_t [N_LANES-1:0]   lanes,
    input  logic                                   flush,
    output mips_exc_pkg::lane_in_t [N_LANES-1:0]   c_lanes
);
    import mips_exc_pkg::*;

    lane_in_t [N_LANES-1:0] lanes_sq;

    // eret has no delay slot, so anything younger in the bundle is dropped
    always_comb begin
        logic eret_seen;

        eret_seen = 1'b0;
        for (int i = 0; i < N_LANES; i++) begin
            lanes_sq[i] = lanes[i];
            if (eret_seen) begin
                lanes_sq[i].valid = 1'b0;
            end
            if (lanes[i].valid && lanes[i].op == OP_ERET) begin
                eret_seen = 1'b1;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // commit register
    // payload follows the input every cycle, only the valid bits are cleared
    always_ff @(posedge clk) begin
        c_lanes <= lanes_sq;
        if (!rst_n || flush) begin
            for (int i = 0; i < N_LANES; i++) begin
                c_lanes[i].valid <= 1'b0;   // flushed slot
            end
        end
    end

endmodule

/* verilog/exc_detect.sv */
`timescale 1ns/1ps

module exc_detect (
    input  mips_exc_pkg::lane_in_t  lane,
    output mips_exc_pkg::lane_exc_t exc
);
    import mips_exc_pkg::*;

    logic inst_misalign;
    logic data_misalign;
    logic is_load;
    logic is_store;

    assign inst_misalign = |lane.pc[1:0];
    assign is_load       = (lane.op == OP_LW) || (lane.op == OP_LH);
    assign is_store      = (lane.op == OP_SW) || (lane.op == OP_SH);

    // word needs both low bits clear, half word only bit 0
    always_comb begin
        case (lane.op)
            OP_LW, OP_SW: data_misalign = |lane.mem_addr[1:0];
            OP_LH, OP_SH: data_misalign = lane.mem_addr[0];
            default:      data_misalign = 1'b0;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // first match wins
    always_comb begin
        exc.valid    = lane.valid;
        exc.bd       = lane.in_delay_slot;
        exc.epc      = lane.in_delay_slot ? lane.pc - 32'd4 : lane.pc;
        exc.kind     = EXC_NONE;
        exc.badvaddr = 32'h0;

        if (lane.valid) begin
            if (inst_misalign) begin
                exc.kind     = EXC_ADEL_I;
                exc.badvaddr = lane.pc;
            end else if (lane.op == OP_RESERVED) begin
                exc.kind = EXC_RI;
            end else if (lane.op == OP_ALU_OV && lane.alu_ovf) begin
                exc.kind = EXC_OV;
            end else if (lane.op == OP_SYSCALL) begin
                exc.kind = EXC_SYS;
            end else if (lane.op == OP_BREAK) begin
                exc.kind = EXC_BP;
            end else if (lane.op == OP_ERET) begin
                exc.kind = EXC_ERET;
            end else if (is_load && data_misalign) begin
                exc.kind     = EXC_ADEL_D;
                exc.badvaddr = lane.mem_addr;
            end else if (is_store && data_misalign) begin
                exc.kind     = EXC_ADES;
                exc.badvaddr = lane.mem_addr;
            end
        end
    end

endmodule

/* verilog/exc_ctrl.sv */
`timescale 1ns/1ps

module exc_ctrl #(
    parameter int          N_LANES    = 2,
    parameter logic [31:0] EXC_VECTOR = 32'hbfc0_0380
) (
    input  mips_exc_pkg::lane_exc_t [N_LANES-1:0] lane_exc,
    input  logic                                  int_pending,
    input  logic [31:0]                           r_epc,
    output mips_exc_pkg::cp0_upd_t                cp0_upd,
    output logic                                  redirect_ena,
    output logic                                  flush,
    output logic [31:0]                           redirect_pc
);
    import mips_exc_pkg::*;

    localparam int IDX_W = (N_LANES > 1) ? $clog2(N_LANES) : 1;

    logic             any_exc;
    logic [IDX_W-1:0] win_idx;
    logic             take_int;
    lane_exc_t        win;

    function automatic exccode_e kind_to_code(input exc_kind_e kind);
        case (kind)
            EXC_ADEL_I: kind_to_code = EC_ADEL;
            EXC_RI:     kind_to_code = EC_RI;
            EXC_OV:     kind_to_code = EC_OV;
            EXC_SYS:    kind_to_code = EC_SYS;
            EXC_BP:     kind_to_code = EC_BP;
            EXC_ADEL_D: kind_to_code = EC_ADEL;
            EXC_ADES:   kind_to_code = EC_ADES;
            default:    kind_to_code = EC_INT;
        endcase
    endfunction

    function automatic logic kind_has_badvaddr(input exc_kind_e kind);
        kind_has_badvaddr = (kind == EXC_ADEL_I) || (kind == EXC_ADEL_D) ||
                            (kind == EXC_ADES);
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // oldest excepting lane, scanned from the youngest so lane 0 lands last
    always_comb begin
        any_exc = 1'b0;
        win_idx = '0;
        for (int i = N_LANES - 1; i >= 0; i--) begin
            if (lane_exc[i].kind != EXC_NONE) begin
                any_exc = 1'b1;
                win_idx = IDX_W'(i);
            end
        end
    end

    assign take_int = int_pending & lane_exc[0].valid;   // interrupt rides on lane 0
    assign win      = lane_exc[win_idx];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // redirect, flush and cp0 update
    always_comb begin
        cp0_upd      = '0;
        redirect_ena = 1'b0;
        redirect_pc  = 32'h0;
        flush        = 1'b0;

        if (take_int) begin
            cp0_upd.update_ena = 1'b1;
            cp0_upd.exccode    = EC_INT;
            cp0_upd.bd         = lane_exc[0].bd;
            cp0_upd.epc        = lane_exc[0].epc;
            redirect_ena       = 1'b1;
            redirect_pc        = EXC_VECTOR;
            flush              = 1'b1;
        end else if (any_exc) begin
            redirect_ena = 1'b1;
            flush        = 1'b1;
            if (win.kind == EXC_ERET) begin
                cp0_upd.cls_exl = 1'b1;         // back to epc, cause untouched
                redirect_pc     = r_epc;
            end else begin
                cp0_upd.update_ena   = 1'b1;
                cp0_upd.exccode      = kind_to_code(win.kind);
                cp0_upd.bd           = win.bd;
                cp0_upd.epc          = win.epc;
                cp0_upd.badvaddr_ena = kind_has_badvaddr(win.kind);
                cp0_upd.badvaddr     = win.badvaddr;
                redirect_pc          = EXC_VECTOR;
            end
        end
    end

endmodule

/* verilog/cp0_regs.sv */
`timescale 1ns/1ps

module cp0_regs (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [5:0]             hw_int,
    input  logic                   cp0_we,
    input  logic [4:0]             cp0_waddr,
    input  logic [31:0]            cp0_wdata,
    input  mips_exc_pkg::cp0_upd_t cp0_upd,
    output logic                   int_pending,
    output logic [31:0]            r_epc,
    output logic [31:0]            badvaddr,
    output mips_exc_pkg::exccode_e cause_exccode,
    output logic                   cause_bd,
    output logic                   status_exl
);
    import mips_exc_pkg::*;

    localparam logic [4:0] REG_STATUS = 5'd12;
    localparam logic [4:0] REG_EPC    = 5'd14;

    logic       status_ie;
    logic [5:0] status_im;      // IM7..IM2, hardware lines only
    logic [5:0] cause_ip;       // IP7..IP2

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // exception update beats eret, eret beats mtc0
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            status_ie     <= 1'b0;
            status_exl    <= 1'b0;
            status_im     <= 6'h0;
            cause_ip      <= 6'h0;
            cause_bd      <= 1'b0;
            cause_exccode <= EC_INT;
            r_epc         <= 32'h0;
            badvaddr      <= 32'h0;
        end else begin
            cause_ip <= hw_int;
            if (cp0_upd.update_ena) begin
                status_exl    <= 1'b1;
                cause_exccode <= cp0_upd.exccode;
                cause_bd      <= cp0_upd.bd;
                r_epc         <= cp0_upd.epc;
                if (cp0_upd.badvaddr_ena) begin
                    badvaddr <= cp0_upd.badvaddr;
                end
            end else if (cp0_upd.cls_exl) begin
                status_exl <= 1'b0;
            end else if (cp0_we) begin
                case (cp0_waddr)
                    REG_STATUS: begin
                        status_ie  <= cp0_wdata[0];
                        status_exl <= cp0_wdata[1];
                        status_im  <= cp0_wdata[15:10];
                    end
                    REG_EPC: begin
                        r_epc <= cp0_wdata;
                    end
                    default: ;  // other registers not writable here
                endcase
            end
        end
    end

    // masked by IM, needs IE and no pending exception level
    assign int_pending = (|(cause_ip & status_im)) & status_ie & ~status_exl;

endmodule

/* verilog/exc_unit_top.sv */
`timescale 1ns/1ps

module exc_unit_top #(
    parameter int          N_LANES    = 2,
    parameter logic [31:0] EXC_VECTOR = 32'hbfc0_0380
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  mips_exc_pkg::lane_in_t [N_LANES-1:0] lanes,
    input  logic [5:0]                           hw_int,
    input  logic                                 cp0_we,
    input  logic [4:0]                           cp0_waddr,
    input  logic [31:0]                          cp0_wdata,
    output logic                                 redirect_ena,
    output logic [31:0]                          redirect_pc,
    output logic                                 flush,
    output logic [31:0]                          epc,
    output mips_exc_pkg::exccode_e               cause_exccode,
    output logic                                 cause_bd,
    output logic                                 status_exl,
    output logic [31:0]                          badvaddr
);
    import mips_exc_pkg::*;

    lane_in_t  [N_LANES-1:0] c_lanes;
    lane_exc_t [N_LANES-1:0] lane_exc;
    cp0_upd_t                cp0_upd;
    logic                    int_pending;
    logic [31:0]             r_epc;

    commit_lanes #(
        .N_LANES (N_LANES)
    ) u_commit (
        .clk     (clk),
        .rst_n   (rst_n),
        .lanes   (lanes),
        .flush   (flush),       // drops the bundle behind an exception
        .c_lanes (c_lanes)
    );

    for (genvar g = 0; g < N_LANES; g++) begin : g_detect
        exc_detect u_detect (
            .lane (c_lanes[g]),
            .exc  (lane_exc[g])
        );
    end

    exc_ctrl #(
        .N_LANES    (N_LANES),
        .EXC_VECTOR (EXC_VECTOR)
    ) u_ctrl (
        .lane_exc     (lane_exc),
        .int_pending  (int_pending),
        .r_epc        (r_epc),
        .cp0_upd      (cp0_upd),
        .redirect_ena (redirect_ena),
        .flush        (flush),
        .redirect_pc  (redirect_pc)
    );

    cp0_regs u_cp0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .hw_int        (hw_int),
        .cp0_we        (cp0_we),
        .cp0_waddr     (cp0_waddr),
        .cp0_wdata     (cp0_wdata),
        .cp0_upd       (cp0_upd),
        .int_pending   (int_pending),
        .r_epc         (r_epc),
        .badvaddr      (badvaddr),
        .cause_exccode (cause_exccode),
        .cause_bd      (cause_bd),
        .status_exl    (status_exl)
    );

    assign epc = r_epc;

endmodule

/* bench/exc_unit_chk.sv */
`timescale 1ns/1ps

module exc_unit_chk #(
    parameter int N_LANES = 2
) (
    input logic                                 clk,
    input logic                                 rst_n,
    input logic                                 flush,
    input logic                                 redirect_ena,
    input mips_exc_pkg::cp0_upd_t               cp0_upd,
    input mips_exc_pkg::lane_in_t [N_LANES-1:0] c_lanes
);
    import mips_exc_pkg::*;

    logic in_reset;     // reset already seen at an earlier edge
    logic eret_shadow;  // valid lane committed behind an eret

    always_ff @(posedge clk) begin
        in_reset <= !rst_n;
    end

    always_comb begin
        logic eret_seen;

        eret_seen   = 1'b0;
        eret_shadow = 1'b0;
        for (int i = 0; i < N_LANES; i++) begin
            if (eret_seen && c_lanes[i].valid) begin
                eret_shadow = 1'b1;
            end
            if (c_lanes[i].valid && c_lanes[i].op == OP_ERET) begin
                eret_seen = 1'b1;
            end
        end
    end

    a_flush_is_redirect: assert property (@(posedge clk) disable iff (!rst_n)
        flush == redirect_ena)
        else $error("flush and redirect_ena disagree");

    a_upd_vs_eret: assert property (@(posedge clk) disable iff (!rst_n)
        !(cp0_upd.update_ena && cp0_upd.cls_exl))
        else $error("exception update and eret in the same cycle");

    a_no_flush_in_reset: assert property (@(posedge clk)
        (!rst_n && in_reset) |-> !flush)
        else $error("flush raised during reset");

    a_no_lane_after_eret: assert property (@(posedge clk) disable iff (!rst_n)
        !eret_shadow)
        else $error("valid lane committed behind an eret");

endmodule

// watches the commit register, controller and cp0 signals inside the top level
bind exc_unit_top exc_unit_chk #(.N_LANES(N_LANES)) u_chk (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush        (flush),
    .redirect_ena (redirect_ena),
    .cp0_upd      (cp0_upd),
    .c_lanes      (c_lanes)
);

/* bench/exc_unit_mon.sv */
`timescale 1ns/1ps

module exc_unit_mon (
    input  logic        clk,
    input  logic        chk_ctrl,       // compare redirect and flush
    input  logic        chk_cp0,        // compare cp0 read ports
    input  logic        exp_flush,
    input  logic [31:0] exp_rpc,
    input  logic [4:0]  exp_code,
    input  logic [31:0] exp_epc,
    input  logic        exp_bd,
    input  logic [31:0] exp_bva,
    input  logic        exp_exl,
    input  logic        flush,
    input  logic        redirect_ena,
    input  logic [31:0] redirect_pc,
    input  logic [31:0] epc,
    input  logic [4:0]  cause_exccode,
    input  logic        cause_bd,
    input  logic        status_exl,
    input  logic [31:0] badvaddr,
    output int          errors
);
    initial errors = 0;

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            errors++;
            $display("CHECK FAILED %s expected %h got %h", name, exp, act);
        end
    endtask

    // sampled mid cycle, well away from the drive point
    always @(negedge clk) begin
        if (chk_ctrl) begin
            compare("flush", {31'h0, exp_flush}, {31'h0, flush});
            compare("redirect_ena", {31'h0, exp_flush}, {31'h0, redirect_ena});
            compare("redirect_pc", exp_rpc, redirect_pc);
        end
        if (chk_cp0) begin
            compare("cause_exccode", {27'h0, exp_code}, {27'h0, cause_exccode});
            compare("epc", exp_epc, epc);
            compare("cause_bd", {31'h0, exp_bd}, {31'h0, cause_bd});
            compare("badvaddr", exp_bva, badvaddr);
            compare("status_exl", {31'h0, exp_exl}, {31'h0, status_exl});
        end
    end

endmodule

/* bench/exc_unit_tb.sv */
`timescale 1ns/1ps

module exc_unit_tb;
    import mips_exc_pkg::*;

    localparam logic [31:0] EV = 32'hbfc0_0380;
    localparam logic        T  = 1'b1;
    localparam logic        F  = 1'b0;

    typedef struct packed {
        lane_in_t    l0;
        lane_in_t    l1;
        logic [5:0]  hw;
        logic [31:0] status;        // written through mtc0 before the bundle
        logic        epc_we;
        logic [31:0] epc_val;
        logic        flush;
        logic [31:0] rpc;
        logic        upd;
        logic [4:0]  code;
        logic [31:0] epc;
        logic        bd;
        logic        bva_en;
        logic [31:0] bva;
        logic        exl;
    } row_t;

    logic clk = 1'b0;
    logic rst_n;
    lane_in_t [1:0] lanes;
    logic [5:0] hw_int;
    logic cp0_we;
    logic [4:0] cp0_waddr;
    logic [31:0] cp0_wdata;
    logic redirect_ena, flush, cause_bd, status_exl;
    logic [31:0] redirect_pc, epc, badvaddr;
    exccode_e cause_exccode;
    logic chk_ctrl, chk_cp0, exp_flush, exp_bd, exp_exl;
    logic [31:0] exp_rpc, exp_epc, exp_bva;
    logic [4:0] exp_code;
    int errors;
    int timeouts;
    int seed;
    row_t rows[$];
    logic [4:0] mdl_code;           // expected cp0 contents
    logic [31:0] mdl_epc, mdl_bva;
    logic mdl_bd;

    always #2 clk = ~clk;

    exc_unit_top #(.N_LANES(2), .EXC_VECTOR(EV)) DUT (
        .clk(clk), .rst_n(rst_n), .lanes(lanes), .hw_int(hw_int),
        .cp0_we(cp0_we), .cp0_waddr(cp0_waddr), .cp0_wdata(cp0_wdata),
        .redirect_ena(redirect_ena), .redirect_pc(redirect_pc), .flush(flush),
        .epc(epc), .cause_exccode(cause_exccode), .cause_bd(cause_bd),
        .status_exl(status_exl), .badvaddr(badvaddr)
    );

    exc_unit_mon mon (
        .clk(clk), .chk_ctrl(chk_ctrl), .chk_cp0(chk_cp0), .exp_flush(exp_flush),
        .exp_rpc(exp_rpc), .exp_code(exp_code), .exp_epc(exp_epc), .exp_bd(exp_bd),
        .exp_bva(exp_bva), .exp_exl(exp_exl), .flush(flush),
        .redirect_ena(redirect_ena), .redirect_pc(redirect_pc), .epc(epc),
        .cause_exccode(cause_exccode), .cause_bd(cause_bd), .status_exl(status_exl),
        .badvaddr(badvaddr), .errors(errors)
    );

    function automatic lane_in_t mk_lane(logic v, logic [31:0] pc, logic ds, op_e op,
                                         logic [31:0] addr, logic ovf);
        mk_lane = '{valid: v, pc: pc, in_delay_slot: ds, op: op, mem_addr: addr,
                    alu_ovf: ovf};
    endfunction

    function automatic lane_in_t nrm(logic [31:0] pc);
        nrm = mk_lane(T, pc, F, OP_NORMAL, 32'h0, F);
    endfunction

    task automatic mtc0_write(input logic [4:0] addr, input logic [31:0] data);
        cp0_we    = 1'b1;
        cp0_waddr = addr;
        cp0_wdata = data;
        @(posedge clk);
        #1 cp0_we = 1'b0;
    endtask

    task automatic apply_row(input row_t r);
        int n;

        mtc0_write(5'd12, r.status);
        if (r.epc_we) begin
            mtc0_write(5'd14, r.epc_val);
            mdl_epc = r.epc_val;
        end
        lanes[0] = r.l0;
        lanes[1] = r.l1;
        hw_int   = r.hw;
        @(posedge clk);             // bundle enters the commit register
        #1;
        lanes     = '0;             // dropped slot behind a flush
        hw_int    = 6'h0;
        exp_flush = r.flush;
        exp_rpc   = r.rpc;
        chk_ctrl  = 1'b1;
        @(posedge clk);
        #1 chk_ctrl = 1'b0;
        n = 0;
        while (flush && n < 100) begin
            @(posedge clk);
            #1 n++;
        end
        if (n == 100) begin
            timeouts++;
            $display("timeout waiting for flush to drop");
        end
        if (r.upd) begin
            mdl_code = r.code;
            mdl_epc  = r.epc;
            mdl_bd   = r.bd;
            if (r.bva_en) mdl_bva = r.bva;
        end
        exp_code = mdl_code;
        exp_epc  = mdl_epc;
        exp_bd   = mdl_bd;
        exp_bva  = mdl_bva;
        exp_exl  = r.exl;
        chk_cp0  = 1'b1;
        @(posedge clk);
        #1 chk_cp0 = 1'b0;
    endtask

    task automatic add_random_rows(input int count);
        logic [31:0] r, addr, pc;
        logic mis;
        op_e op;
        row_t row;

        for (int i = 0; i < count; i++) begin
            r    = $random(seed);
            addr = $random(seed);
            pc   = 32'h0040_1000 + 32'(i * 8);
            case (r[1:0])
                2'd0:    op = OP_LW;
                2'd1:    op = OP_LH;
                2'd2:    op = OP_SW;
                default: op = OP_SH;
            endcase
            // word needs both low bits clear and half word only bit 0
            mis = r[0] ? addr[0] : |addr[1:0];
            row = '0;
            row.l0 = r[2] ? nrm(pc) : mk_lane(T, pc, F, op, addr, F);
            row.l1 = r[2] ? mk_lane(T, pc + 32'd4, F, op, addr, F) : nrm(pc + 32'd4);
            row.flush  = mis;
            row.rpc    = mis ? EV : 32'h0;
            row.upd    = mis;
            row.code   = r[1] ? 5'h05 : 5'h04;
            row.epc    = r[2] ? pc + 32'd4 : pc;
            row.bva_en = 1'b1;
            row.bva    = addr;
            row.exl    = mis;
            rows.push_back(row);
        end
    endtask

    initial begin
        rst_n     = 1'b0;
        lanes     = '0;
        hw_int    = 6'h0;
        cp0_we    = 1'b0;
        cp0_waddr = 5'h0;
        cp0_wdata = 32'h0;
        chk_ctrl  = 1'b0;
        chk_cp0   = 1'b0;
        exp_flush = 1'b0;
        exp_rpc   = 32'h0;
        exp_code  = 5'h0;
        exp_epc   = 32'h0;
        exp_bd    = 1'b0;
        exp_bva   = 32'h0;
        exp_exl   = 1'b0;
        mdl_code  = 5'h0;
        mdl_epc   = 32'h0;
        mdl_bd    = 1'b0;
        mdl_bva   = 32'h0;
        timeouts  = 0;
        seed      = 69067;

        // l0, l1, hw, status, epc_we, epc_val, flush, rpc, upd, code, epc, bd, bva_en, bva, exl
        rows.push_back('{nrm(32'h400000), nrm(32'h400004), 6'h0, 32'h0, F, 32'h0,
            F, 32'h0, F, 5'h0, 32'h0, F, F, 32'h0, F});
        rows.push_back('{mk_lane(T, 32'h400100, F, OP_RESERVED, 32'h0, F), nrm(32'h400104),
            6'h0, 32'h0, F, 32'h0, T, EV, T, 5'h0a, 32'h400100, F, F, 32'h0, T});
        rows.push_back('{nrm(32'h400200), mk_lane(T, 32'h400204, F, OP_ALU_OV, 32'h0, T),
            6'h0, 32'h0, F, 32'h0, T, EV, T, 5'h0c, 32'h400204, F, F, 32'h0, T});
        rows.push_back('{mk_lane(T, 32'h400280, F, OP_ALU_OV, 32'h0, F), nrm(32'h400284),
            6'h0, 32'h0, F, 32'h0, F, 32'h0, F, 5'h0, 32'h0, F, F, 32'h0, F});
        rows.push_back('{mk_lane(T, 32'h400304, T, OP_SYSCALL, 32'h0, F), nrm(32'h400308),
            6'h0, 32'h0, F, 32'h0, T, EV, T, 5'h08, 32'h400300, T, F, 32'h0, T});
        rows.push_back('{mk_lane(T, 32'h400400, F, OP_BREAK, 32'h0, F),
            mk_lane(T, 32'h400404, F, OP_SYSCALL, 32'h0, F),
            6'h0, 32'h0, F, 32'h0, T, EV, T, 5'h09, 32'h400400, F, F, 32'h0, T});
        rows.push_back('{mk_lane(T, 32'h400502, F, OP_RESERVED, 32'h0, F), nrm(32'h400506),
            6'h0, 32'h0, F, 32'h0, T, EV, T, 5'h04, 32'h400502, F, T, 32'h400502, T});
        rows.push_back('{nrm(32'h400600), mk_lane(T, 32'h400604, F, OP_LW, 32'h1002, F),
            6'h0, 32'h0, F, 32'h0, T, EV, T, 5'h04, 32'h400604, F, T, 32'h1002, T});
        rows.push_back('{mk_lane(T, 32'h400700, F, OP_SH, 32'h2001, F), nrm(32'h400704),
            6'h0, 32'h0, F, 32'h0, T, EV, T, 5'h05, 32'h400700, F, T, 32'h2001, T});
        rows.push_back('{mk_lane(T, 32'h400800, F, OP_SW, 32'h3000, F), nrm(32'h400804),
            6'h0, 32'h0, F, 32'h0, F, 32'h0, F, 5'h0, 32'h0, F, F, 32'h0, F});
        // eret back to the written epc with the younger syscall squashed
        rows.push_back('{mk_lane(T, 32'h400900, F, OP_ERET, 32'h0, F),
            mk_lane(T, 32'h400904, F, OP_SYSCALL, 32'h0, F),
            6'h0, 32'h2, T, 32'h80001000, T, 32'h80001000, F, 5'h0, 32'h0, F, F, 32'h0, F});
        rows.push_back('{nrm(32'h400a00), nrm(32'h400a04), 6'h01, 32'h401, F, 32'h0,
            T, EV, T, 5'h00, 32'h400a00, F, F, 32'h0, T});
        rows.push_back('{nrm(32'h400b00), nrm(32'h400b04), 6'h01, 32'h400, F, 32'h0,
            F, 32'h0, F, 5'h0, 32'h0, F, F, 32'h0, F});
        rows.push_back('{nrm(32'h400c00), nrm(32'h400c04), 6'h01, 32'h403, F, 32'h0,
            F, 32'h0, F, 5'h0, 32'h0, F, F, 32'h0, T});
        rows.push_back('{mk_lane(F, 32'h400d00, F, OP_NORMAL, 32'h0, F), nrm(32'h400d04),
            6'h01, 32'h401, F, 32'h0, F, 32'h0, F, 5'h0, 32'h0, F, F, 32'h0, F});
        add_random_rows(40);

        repeat (10) @(posedge clk);
        #1 rst_n = 1'b1;
        foreach (rows[i]) apply_row(rows[i]);
        repeat (2) @(posedge clk);

        $display("checks failed %0d, timeouts %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* exc_unit_top.f */
verilog/mips_exc_pkg.sv
verilog/commit_lanes.sv
verilog/exc_detect.sv
verilog/exc_ctrl.sv
verilog/cp0_regs.sv
verilog/exc_unit_top.sv
bench/exc_unit_chk.sv
bench/exc_unit_mon.sv
bench/exc_unit_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the exception unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module exc_unit_tb \
    -f exc_unit_top.f -o exc_unit_sim || exit 1

out="$(./obj_dir/exc_unit_sim)"
echo "$out"
echo "$out" | grep -qx "NO ERRORS" && exit 0 || exit 1
